//--- src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int WORD_W  = 16;
	localparam int FIELD_W = 4;	// Width of opcode and register fields

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [FIELD_W-1:0] reg_idx_t;

	// Subset of the full ISA, encodings unchanged
	typedef enum logic [3:0] {
		OP_ADD = 4'b0000,
		OP_SUB = 4'b0001,
		OP_XOR = 4'b0010,
		OP_LW  = 4'b1000,
		OP_SW  = 4'b1001,
		OP_LHB = 4'b1010,
		OP_LLB = 4'b1011,
		OP_HLT = 4'b1111
	} opcode_e;

	localparam int OP_MSB = 15;	// Opcode [15:12]
	localparam int RD_MSB = 11;	// Dest, or store data [11:8]
	localparam int RS_MSB = 7;	// Source 1 or base [7:4], byte imm [7:0]
	localparam int RT_MSB = 3;	// Source 2 or offset [3:0]

endpackage

`default_nettype wire

//--- src/cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

	// Line geometry
	localparam int LINE_WORDS  = 4;
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);	// Word offset within line

	// Cache numbering on the shared memory
	localparam int PORT_I    = 0;	// Instruction side, higher priority
	localparam int PORT_D    = 1;
	localparam int NUM_PORTS = 2;

	// Stores live at and above this address, program below it
	localparam logic [15:0] DATA_BASE = 16'h8000;

endpackage

`default_nettype wire

//--- src/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if
	import cpu_isa_pkg::*;
();

	logic  req;	// One-cycle strobe
	logic  we;
	word_t addr;	// Byte address, bit 0 ignored
	word_t wdata;
	logic  rdy;	// One-cycle completion pulse
	word_t rdata;	// Valid with rdy on reads

	modport client (
		output req, we, addr, wdata,
		input  rdy, rdata
	);

	modport server (
		input  req, we, addr, wdata,
		output rdy, rdata
	);

endinterface

`default_nettype wire

//--- src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
	import cpu_isa_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  wire      run,
	mem_if.client    imem,
	mem_if.client    dmem,
	output logic     wb_valid,
	output reg_idx_t wb_reg,
	output word_t    wb_data,
	output logic     hlt,
	output word_t    pc_out
);

	// Fetch state
	word_t pc;
	word_t slot_pc;	// Address of instruction in decode slot
	word_t slot_instr;
	logic  slot_valid;
	logic  fetch_pend;

	// Register file and scoreboard
	word_t       regs [16];
	logic [15:0] pend;	// One pending-write bit per register
	logic [1:0]  wb_owed;	// Register writes issued, not yet written back

	// Data-side request, held until dmem.rdy
	logic     mem_busy;
	logic     mem_lw;
	reg_idx_t mem_rd;
	logic     dreq, dwe;
	word_t    daddr, dwdata;

	// Decode
	opcode_e  op;
	reg_idx_t rd, rs, rt, s1_idx, s2_idx;
	logic     use1, use2, writes_reg, hazard, issue, fetch;
	word_t    src1, src2, alu_res, ea, mem_addr;
	logic [7:0] imm8;

	//------------------------------------------------------------------------
	// Decode and issue
	//------------------------------------------------------------------------
	always_comb begin
		op   = opcode_e'(slot_instr[OP_MSB -: FIELD_W]);
		rd   = slot_instr[RD_MSB -: FIELD_W];
		rs   = slot_instr[RS_MSB -: FIELD_W];
		rt   = slot_instr[RT_MSB -: FIELD_W];
		imm8 = slot_instr[RS_MSB:0];

		// LHB/LLB read the old value of their own dest
		s1_idx = (op inside {OP_LHB, OP_LLB}) ? rd : rs;
		s2_idx = (op == OP_SW) ? rd : rt;	// SW data lives in the rd field
		use1   = op inside {OP_ADD, OP_SUB, OP_XOR, OP_LW, OP_SW, OP_LHB, OP_LLB};
		use2   = op inside {OP_ADD, OP_SUB, OP_XOR, OP_SW};
		writes_reg = op inside {OP_ADD, OP_SUB, OP_XOR, OP_LW, OP_LHB, OP_LLB};

		src1 = regs[s1_idx];	// r0 never written, reads zero
		src2 = regs[s2_idx];

		hazard = (use1 && pend[s1_idx]) || (use2 && pend[s2_idx]);
		issue  = slot_valid && !mem_busy && !hlt && !hazard;

		// Fetch stops once HLT leaves the slot
		fetch = run && !hlt && !fetch_pend &&
			(!slot_valid || (issue && op != OP_HLT));

		case (op)
			OP_ADD:  alu_res = src1 + src2;
			OP_SUB:  alu_res = src1 - src2;
			OP_XOR:  alu_res = src1 ^ src2;
			OP_LHB:  alu_res = {imm8, src1[7:0]};
			OP_LLB:  alu_res = {src1[15:8], imm8};
			default: alu_res = '0;
		endcase

		// Base + (sext offset << 1), halfword aligned
		ea       = src1 + {{(WORD_W-FIELD_W-1){rt[FIELD_W-1]}}, rt, 1'b0};
		mem_addr = {ea[WORD_W-1:1], 1'b0};
	end

	assign imem.req   = fetch;
	assign imem.we    = 1'b0;	// I side is read only
	assign imem.addr  = pc;
	assign imem.wdata = '0;

	assign dmem.req   = dreq;
	assign dmem.we    = dwe;
	assign dmem.addr  = daddr;
	assign dmem.wdata = dwdata;

	assign pc_out = pc;

	// Fetch and decode slot
	always_ff @(posedge clk) begin
		if (reset) begin
			pc         <= '0;
			slot_valid <= 1'b0;
			fetch_pend <= 1'b0;
		end else begin
			if (fetch)
				fetch_pend <= 1'b1;
			else if (imem.rdy)
				fetch_pend <= 1'b0;

			// Slot is always empty while a fetch is out
			if (imem.rdy) begin
				slot_valid <= 1'b1;
				slot_instr <= imem.rdata;
				slot_pc    <= pc;
				pc         <= pc + 16'd2;
			end else if (issue) begin
				slot_valid <= 1'b0;
				if (op == OP_HLT)
					pc <= slot_pc;	// Park on HLT address
			end
		end
	end

	// Register file and scoreboard
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			pend <= '0;
		end else begin
			if (wb_valid && wb_reg != '0)
				regs[wb_reg] <= wb_data;
			// Clear first so a new issue to the same reg wins
			if (wb_valid)
				pend[wb_reg] <= 1'b0;
			if (issue && writes_reg && rd != '0)
				pend[rd] <= 1'b1;
		end
	end

	//------------------------------------------------------------------------
	// Execute and writeback
	//------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			hlt      <= 1'b0;
			mem_busy <= 1'b0;
			mem_lw   <= 1'b0;
			dreq     <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			dreq     <= 1'b0;
			if (issue) begin
				case (op)
					OP_ADD, OP_SUB, OP_XOR, OP_LHB, OP_LLB: begin
						wb_valid <= 1'b1;	// Result one cycle after issue
						wb_reg   <= rd;
						wb_data  <= alu_res;
					end
					OP_LW, OP_SW: begin
						mem_busy <= 1'b1;	// Blocks further issue
						mem_lw   <= (op == OP_LW);
						mem_rd   <= rd;
						dreq     <= 1'b1;
						dwe      <= (op == OP_SW);
						daddr    <= mem_addr;
						dwdata   <= src2;
					end
					OP_HLT: hlt <= 1'b1;	// Sticky
					default: ;	// Unsupported opcodes drop out
				endcase
			end
			if (dmem.rdy) begin
				mem_busy <= 1'b0;
				if (mem_lw) begin
					wb_valid <= 1'b1;
					wb_reg   <= mem_rd;
					wb_data  <= dmem.rdata;
				end
			end
		end
	end

	// Writebacks owed by issued register writers, SW and HLT add none
	always_ff @(posedge clk) begin
		if (reset)
			wb_owed <= '0;
		else
			wb_owed <= wb_owed + 2'(issue && writes_reg) - 2'(wb_valid);
	end

	// No writeback slot for SW or HLT
	a_wb_owed: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> wb_owed != '0);

endmodule

`default_nettype wire

//--- src/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache
	import cpu_isa_pkg::*, cpu_mem_pkg::*;
#(
	parameter int CACHE_LINES = 8	// Power of two
) (
	input  wire   clk,
	input  wire   reset,
	mem_if.server cpu,
	mem_if.client mem
);

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int TAG_BITS   = WORD_W - 1 - OFFSET_BITS - INDEX_BITS;
	localparam logic [OFFSET_BITS-1:0] LAST_WORD = OFFSET_BITS'(LINE_WORDS - 1);

	typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_FILL, S_WRITE} state_e;

	// Line storage
	logic [TAG_BITS-1:0]    tags [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid;
	word_t                  lines [CACHE_LINES][LINE_WORDS];

	state_e state;
	logic   req_we;	// Latched CPU request
	word_t  req_addr, req_wdata;
	logic [OFFSET_BITS-1:0] fill_cnt;
	logic   wr_done;	// Memory write acknowledged
	logic   mem_req_q, mem_we_q;
	word_t  mem_addr_q, mem_wdata_q;
	logic   cpu_open;	// Port-level request tracking

	logic [OFFSET_BITS-1:0] off;
	logic [INDEX_BITS-1:0]  idx;
	logic [TAG_BITS-1:0]    tag;
	logic hit, fill_last;

	// Address split: tag | index | word offset | byte
	assign off = req_addr[OFFSET_BITS:1];
	assign idx = req_addr[OFFSET_BITS+INDEX_BITS:OFFSET_BITS+1];
	assign tag = req_addr[WORD_W-1 -: TAG_BITS];
	assign hit = valid[idx] && (tags[idx] == tag);
	assign fill_last = (state == S_FILL) && mem.rdy && (fill_cnt == LAST_WORD);

	// Answer from LOOKUP, writes only once memory acked
	assign cpu.rdy   = (state == S_LOOKUP) && (req_we ? wr_done : hit);
	assign cpu.rdata = lines[idx][off];

	assign mem.req   = mem_req_q;
	assign mem.we    = mem_we_q;
	assign mem.addr  = mem_addr_q;
	assign mem.wdata = mem_wdata_q;

	// Tag and data arrays
	always_ff @(posedge clk) begin
		if (state == S_FILL && mem.rdy)
			lines[idx][fill_cnt] <= mem.rdata;
		if (fill_last)
			tags[idx] <= tag;
		if (state == S_LOOKUP && req_we && !wr_done && hit)
			lines[idx][off] <= req_wdata;	// Store hit keeps line current
	end

	//------------------------------------------------------------------------
	// Control FSM
	//------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			valid     <= '0;
			fill_cnt  <= '0;
			wr_done   <= 1'b0;
			mem_req_q <= 1'b0;
		end else begin
			mem_req_q <= 1'b0;
			case (state)
				S_IDLE: if (cpu.req) begin
					req_we    <= cpu.we;
					req_addr  <= cpu.addr;
					req_wdata <= cpu.wdata;
					state     <= S_LOOKUP;
				end
				S_LOOKUP: begin
					if (req_we) begin
						if (wr_done) begin
							wr_done <= 1'b0;
							state   <= S_IDLE;
						end else begin
							// Write-through, no allocate on miss
							mem_req_q   <= 1'b1;
							mem_we_q    <= 1'b1;
							mem_addr_q  <= req_addr;
							mem_wdata_q <= req_wdata;
							state       <= S_WRITE;
						end
					end else if (hit) begin
						state <= S_IDLE;
					end else begin
						valid[idx] <= 1'b0;	// Line is stale until fill ends
						mem_req_q  <= 1'b1;
						mem_we_q   <= 1'b0;
						mem_addr_q <= {req_addr[WORD_W-1:OFFSET_BITS+1],
							{OFFSET_BITS{1'b0}}, 1'b0};
						fill_cnt   <= '0;
						state      <= S_FILL;
					end
				end
				S_FILL: if (mem.rdy) begin
					if (fill_cnt == LAST_WORD) begin
						valid[idx] <= 1'b1;
						state      <= S_LOOKUP;	// Now hits
					end else begin
						fill_cnt   <= fill_cnt + 1'b1;
						mem_req_q  <= 1'b1;
						mem_addr_q <= {req_addr[WORD_W-1:OFFSET_BITS+1],
							OFFSET_BITS'(fill_cnt + 1'b1), 1'b0};
					end
				end
				S_WRITE: if (mem.rdy) begin
					wr_done <= 1'b1;
					state   <= S_LOOKUP;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Request history seen on the CPU port
	always_ff @(posedge clk) begin
		if (reset)
			cpu_open <= 1'b0;
		else if (cpu.req)
			cpu_open <= 1'b1;
		else if (cpu.rdy)
			cpu_open <= 1'b0;
	end

	a_rdy_has_req: assert property (@(posedge clk) disable iff (reset)
		cpu.rdy |-> cpu_open);

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
	import cpu_isa_pkg::*, cpu_mem_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	mem_if.server client [NUM_PORTS],
	mem_if.client mem
);

	// Flattened client requests
	logic [NUM_PORTS-1:0] req_in, we_in;
	word_t                addr_in [NUM_PORTS];
	word_t                wdata_in [NUM_PORTS];

	// Held requests waiting for a grant
	logic [NUM_PORTS-1:0] pend, p_we;
	word_t                p_addr [NUM_PORTS];
	word_t                p_wdata [NUM_PORTS];

	logic  busy;	// Memory owned until its rdy
	logic  owner;
	logic  gnt_valid, gnt_idx;
	logic  mem_req_q, mem_we_q;
	word_t mem_addr_q, mem_wdata_q;
	logic  mem_open;

	// Fixed priority, I side first
	assign gnt_valid = !busy && (|pend);
	assign gnt_idx   = pend[PORT_I] ? 1'(PORT_I) : 1'(PORT_D);

	assign mem.req   = mem_req_q;
	assign mem.we    = mem_we_q;
	assign mem.addr  = mem_addr_q;
	assign mem.wdata = mem_wdata_q;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		logic open;

		assign req_in[i]      = client[i].req;
		assign we_in[i]       = client[i].we;
		assign addr_in[i]     = client[i].addr;
		assign wdata_in[i]    = client[i].wdata;
		assign client[i].rdy   = mem.rdy && busy && (owner == 1'(i));	// Owner only
		assign client[i].rdata = mem.rdata;

		always_ff @(posedge clk) begin
			if (reset)
				open <= 1'b0;
			else if (client[i].req)
				open <= 1'b1;
			else if (client[i].rdy)
				open <= 1'b0;
		end

		a_rdy_to_owner: assert property (@(posedge clk) disable iff (reset)
			client[i].rdy |-> open);
	end

	//------------------------------------------------------------------------
	// Request latch and grant
	//------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pend      <= '0;
			busy      <= 1'b0;
			owner     <= 1'b0;
			mem_req_q <= 1'b0;
		end else begin
			mem_req_q <= 1'b0;
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (req_in[i]) begin
					pend[i]    <= 1'b1;
					p_we[i]    <= we_in[i];
					p_addr[i]  <= addr_in[i];
					p_wdata[i] <= wdata_in[i];
				end
			end
			if (gnt_valid) begin
				pend[gnt_idx] <= 1'b0;
				busy          <= 1'b1;
				owner         <= gnt_idx;
				mem_req_q     <= 1'b1;
				mem_we_q      <= p_we[gnt_idx];
				mem_addr_q    <= p_addr[gnt_idx];
				mem_wdata_q   <= p_wdata[gnt_idx];
			end
			if (mem.rdy)
				busy <= 1'b0;
		end
	end

	// Outstanding memory access
	always_ff @(posedge clk) begin
		if (reset)
			mem_open <= 1'b0;
		else if (mem.req)
			mem_open <= 1'b1;
		else if (mem.rdy)
			mem_open <= 1'b0;
	end

	a_one_mem_req: assert property (@(posedge clk) disable iff (reset)
		mem.req |-> !mem_open);

endmodule

`default_nettype wire

//--- src/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory
	import cpu_isa_pkg::*;
#(
	parameter int MEM_LATENCY = 4,	// At least 1
	parameter int MEM_WORDS   = 65536
) (
	input  wire   clk,
	input  wire   reset,
	input  wire   load_we,
	input  word_t load_addr,
	input  word_t load_data,
	mem_if.server port
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int CW = $clog2(MEM_LATENCY + 1);

	word_t mem [MEM_WORDS];

	logic          busy;
	logic [CW-1:0] cnt;	// Cycles left until rdy
	logic [AW-1:0] rd_idx;

	assign port.rdy   = busy && (cnt == '0);
	assign port.rdata = mem[rd_idx];

	// Word array, indexed by addr[15:1]
	always_ff @(posedge clk) begin
		if (load_we)
			mem[AW'(load_addr[WORD_W-1:1])] <= load_data;
		if (port.req) begin
			rd_idx <= AW'(port.addr[WORD_W-1:1]);
			if (port.we)
				mem[AW'(port.addr[WORD_W-1:1])] <= port.wdata;	// Lands on accept
		end
	end

	// Latency countdown
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (port.req) begin
			busy <= 1'b1;
			cnt  <= CW'(MEM_LATENCY - 1);
		end else if (busy) begin
			if (cnt == '0)
				busy <= 1'b0;
			else
				cnt <= cnt - 1'b1;
		end
	end

	a_not_busy: assert property (@(posedge clk) disable iff (reset)
		port.req |-> !busy);

endmodule

`default_nettype wire

//--- src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
	import cpu_isa_pkg::*, cpu_mem_pkg::*;
#(
	parameter int CACHE_LINES = 8,
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 65536
) (
	input  wire      clk,
	input  wire      reset,
	input  wire      run,	// Enables fetch
	input  wire      load_we,
	input  word_t    load_addr,
	input  word_t    load_data,
	output logic     wb_valid,
	output reg_idx_t wb_reg,
	output word_t    wb_data,
	output logic     hlt,
	output word_t    pc_out
);

	mem_if core_port [NUM_PORTS] ();	// Core to caches
	mem_if fill_port [NUM_PORTS] ();	// Caches to arbiter
	mem_if mem_port ();

	cpu_core core_i (
		.clk      (clk),
		.reset    (reset),
		.run      (run),
		.imem     (core_port[PORT_I]),
		.dmem     (core_port[PORT_D]),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data),
		.hlt      (hlt),
		.pc_out   (pc_out)
	);

	//------------------------------------------------------------------------
	// I and D caches, same RTL
	//------------------------------------------------------------------------
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_cache
		cache #(.CACHE_LINES(CACHE_LINES)) cache_i (
			.clk   (clk),
			.reset (reset),
			.cpu   (core_port[i]),
			.mem   (fill_port[i])
		);
	end

	mem_arbiter arb_i (
		.clk    (clk),
		.reset  (reset),
		.client (fill_port),
		.mem    (mem_port)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) mem_i (
		.clk       (clk),
		.reset     (reset),
		.load_we   (load_we && !run),	// Loads locked out while running
		.load_addr (load_addr),
		.load_data (load_data),
		.port      (mem_port)
	);

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
	import cpu_isa_pkg::*, cpu_mem_pkg::*;
();

	localparam int CACHE_LINES  = 8;
	localparam int MEM_LATENCY  = 4;
	localparam int MEM_WORDS    = 65536;
	localparam int PROG_LEN     = 200;	// Instructions before the HLT
	localparam int DATA_WORDS   = 16;	// Random words at DATA_BASE
	localparam int REGION_WORDS = 144;	// 36 lines, well past the cache size
	localparam logic [15:0] HLT_ADDR = 16'(2 * PROG_LEN);
	localparam int RUN_CYCLES = (PROG_LEN + 1) * 2 * (LINE_WORDS * MEM_LATENCY + 4);
	localparam int WATCHDOG_CYCLES = 16 + (PROG_LEN + 1) + REGION_WORDS + 60 + RUN_CYCLES;

	logic     clk, reset, run, load_we;
	word_t    load_addr, load_data;
	logic     wb_valid, hlt;
	reg_idx_t wb_reg;
	word_t    wb_data, pc_out;

	logic [31:0] lfsr;
	word_t       prog [PROG_LEN+1];
	word_t       load_a [$];	// Memory image, program then data
	word_t       load_d [$];
	reg_idx_t    exp_reg [$];	// Expected writebacks in order
	word_t       exp_data [$];
	word_t       ref_mem [32768];	// Model memory by word index
	int          errors, wb_seen, late_wb;

	cpu #(
		.CACHE_LINES (CACHE_LINES),
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) dut_i (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.hlt       (hlt),
		.pc_out    (pc_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	//------------------------------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------------------------------
	// Galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// Background for the data region beyond the random words
	function automatic word_t fill_word(input word_t addr);
		return (addr * 16'h9E37) ^ {addr[7:0], addr[15:8]};
	endfunction

	function automatic void gen_program();
		int         n;
		logic [2:0] kind;
		reg_idx_t   rd, rs, rt, rb;
		logic [3:0] off, last_off;
		word_t      base, last_base;
		logic       have_last, is_sw;
		n = 0;
		have_last = 1'b0;
		last_base = '0;
		last_off = '0;
		while (n < PROG_LEN) begin
			kind = 3'(take_bits(3));
			rd = 4'(take_bits(3));	// r0..r7 keeps dependencies close
			if (kind <= 3'd2) begin
				rs = 4'(take_bits(3));
				rt = 4'(take_bits(3));
				prog[n] = {1'b0, kind, rd, rs, rt};	// ADD/SUB/XOR codes are 0..2
				n++;
			end else if (kind <= 3'd4 || n + 3 > PROG_LEN) begin
				prog[n] = {(kind == 3'd3) ? OP_LHB : OP_LLB, rd, 8'(take_bits(8))};
				n++;
			end else begin
				rb = 4'(take_bits(3));
				if (rb == '0)
					rb = 4'd1;	// Base in r0 would leave data space
				if (have_last && take_bits(1)) begin
					base = last_base;	// Revisit last address, store then load
					off  = last_off;
				end else begin
					base = 16'h8010 + (take_bits(7) << 1);
					off  = 4'(take_bits(4));
				end
				is_sw = take_bits(1);
				prog[n]   = {OP_LLB, rb, base[7:0]};
				prog[n+1] = {OP_LHB, rb, base[15:8]};
				prog[n+2] = {is_sw ? OP_SW : OP_LW, rd, rb, off};
				last_base = base;
				last_off  = off;
				have_last = 1'b1;
				n += 3;
			end
		end
		prog[PROG_LEN] = {OP_HLT, 12'h000};
	endfunction

	function automatic void build_image();
		word_t a;
		for (int i = 0; i <= PROG_LEN; i++) begin
			load_a.push_back(16'(2 * i));
			load_d.push_back(prog[i]);
		end
		for (int i = 0; i < REGION_WORDS; i++) begin
			a = DATA_BASE + 16'(2 * i);
			load_a.push_back(a);
			load_d.push_back((i < DATA_WORDS) ? take_bits(16) : fill_word(a));
		end
	endfunction

	//------------------------------------------------------------------------
	// Reference model, program order
	//------------------------------------------------------------------------
	function automatic void compute_expected();
		word_t    r [16];
		word_t    ins, res, ea;
		reg_idx_t rd, rs, rt;
		logic     wr;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		foreach (load_a[k])
			ref_mem[load_a[k][15:1]] = load_d[k];
		for (int i = 0; i <= PROG_LEN; i++) begin
			ins = prog[i];
			rd = ins[11:8];
			rs = ins[7:4];
			rt = ins[3:0];
			ea = r[rs] + {{11{rt[3]}}, rt, 1'b0};	// Base + sext(off) << 1
			ea[0] = 1'b0;
			wr = 1'b1;
			res = '0;
			case (ins[15:12])
				OP_ADD: res = r[rs] + r[rt];
				OP_SUB: res = r[rs] - r[rt];
				OP_XOR: res = r[rs] ^ r[rt];
				OP_LHB: res = {ins[7:0], r[rd][7:0]};
				OP_LLB: res = {r[rd][15:8], ins[7:0]};
				OP_LW:  res = ref_mem[ea[15:1]];
				OP_SW: begin
					ref_mem[ea[15:1]] = r[rd];	// Store data sits in rd field
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				exp_reg.push_back(rd);	// r0 still shows a writeback
				exp_data.push_back(res);
				if (rd != '0)
					r[rd] = res;
			end
			if (ins[15:12] == OP_HLT)
				break;
		end
	endfunction

	// Writeback checker, values from the cycle before the edge
	always @(posedge clk) begin
		if (!reset && wb_valid === 1'b1) begin
			if (hlt === 1'b1) begin
				late_wb++;
				errors++;
				$display("Writeback to r%0d seen after HLT", wb_reg);
			end else if (wb_seen >= exp_reg.size()) begin
				errors++;
				$display("Extra writeback to r%0d beyond the %0d expected",
					wb_reg, exp_reg.size());
			end else begin
				if (wb_reg !== exp_reg[wb_seen]) begin
					errors++;
					$display("Fail wb_reg #%0d: expected %h, got %h",
						wb_seen, exp_reg[wb_seen], wb_reg);
				end
				if (wb_data !== exp_data[wb_seen]) begin
					errors++;
					$display("Fail wb_data #%0d: expected %h, got %h",
						wb_seen, exp_data[wb_seen], wb_data);
				end
			end
			wb_seen++;
		end
	end

	initial begin
		reset     = 1'b1;
		run       = 1'b0;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		errors    = 0;
		wb_seen   = 0;
		late_wb   = 0;
		lfsr      = 32'd81548;
		gen_program();
		build_image();
		compute_expected();

		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Memory image through the load port, one word per cycle
		foreach (load_a[k]) begin
			@(posedge clk);
			load_we   <= 1'b1;
			load_addr <= load_a[k];
			load_data <= load_d[k];
		end
		@(posedge clk);
		load_we <= 1'b0;
		run     <= 1'b1;

		do
			@(posedge clk);
		while (hlt !== 1'b1);
		if (pc_out !== HLT_ADDR) begin
			errors++;
			$display("Fail pc_out: expected %h, got %h", HLT_ADDR, pc_out);
		end

		repeat (50) @(posedge clk);	// Quiet period after halt
		if (hlt !== 1'b1) begin
			errors++;
			$display("hlt dropped after the processor halted");
		end
		if (wb_seen < exp_reg.size()) begin
			errors++;
			$display("Missing writebacks: expected %0d, saw %0d", exp_reg.size(), wb_seen);
		end

		$display("Writebacks %0d of %0d, after halt %0d, errors %0d",
			wb_seen, exp_reg.size(), late_wb, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles, writebacks %0d, errors %0d",
			WATCHDOG_CYCLES, wb_seen, errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
src/cpu_isa_pkg.sv
src/cpu_mem_pkg.sv
src/mem_if.sv
src/cpu_core.sv
src/cache.sv
src/mem_arbiter.sv
src/main_memory.sv
src/cpu.sv
bench/cpu_tb.sv
